/* src/dcache_pkg.sv */
package dcache_pkg;

    localparam int addr_w      = 16;
    localparam int data_w      = 32;
    localparam int index_w     = 4;
    localparam int tag_w       = addr_w - index_w - 2;  // includes select bit, zero for memory
    localparam int be_addr_w   = addr_w - 2;            // word address
    localparam int line_count  = 1 << index_w;
    localparam int wtbuf_depth = 4;
    localparam int wtbuf_ptr_w = $clog2(wtbuf_depth);
    localparam int ctrl_off_w  = 4;

    // word offsets inside the control space
    typedef enum logic [ctrl_off_w-1:0] {
        ctrl_hit            = 4'd0,
        ctrl_miss           = 4'd1,
        ctrl_read_hit       = 4'd2,
        ctrl_read_miss      = 4'd3,
        ctrl_write_hit      = 4'd4,
        ctrl_write_miss     = 4'd5,
        ctrl_reset_counters = 4'd6,
        ctrl_invalidate     = 4'd7,
        ctrl_buffer_empty   = 4'd8,
        ctrl_buffer_full    = 4'd9
    } ctrl_addr_e;

    typedef enum logic [2:0] {
        core_idle,
        core_lookup,
        core_refill,
        core_store,
        core_done
    } core_state_e;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } fe_req_t;

    typedef struct packed {
        logic              ready;
        logic [data_w-1:0] rdata;
    } fe_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [be_addr_w-1:0] addr;
        logic [data_w-1:0]    wdata;
    } be_req_t;

    typedef struct packed {
        logic              ready;
        logic [data_w-1:0] rdata;
    } be_rsp_t;

    typedef struct packed {
        logic [be_addr_w-1:0] addr;
        logic [data_w-1:0]    wdata;
    } wt_entry_t;

    typedef struct packed {
        logic read_hit;
        logic read_miss;
        logic write_hit;
        logic write_miss;
    } cache_event_t;

endpackage

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  dcache_pkg::fe_req_t      fe_req,
    output dcache_pkg::fe_rsp_t      fe_rsp,
    input  dcache_pkg::cache_event_t events,
    input  logic                     wtbuf_empty,
    input  logic                     wtbuf_full,
    output logic                     invalidate
);
    import dcache_pkg::*;

    logic [data_w-1:0] read_hit_cnt;
    logic [data_w-1:0] read_miss_cnt;
    logic [data_w-1:0] write_hit_cnt;
    logic [data_w-1:0] write_miss_cnt;
    logic [data_w-1:0] hit_cnt;
    logic [data_w-1:0] miss_cnt;
    logic [data_w-1:0] rdata_q;
    logic              ready_q;
    logic              counter_reset;
    logic              accept;
    ctrl_addr_e        offset;

    assign hit_cnt  = read_hit_cnt + write_hit_cnt;
    assign miss_cnt = read_miss_cnt + write_miss_cnt;

    // valid stays up during the ready cycle, so skip it there
    assign accept = fe_req.valid && !ready_q;
    assign offset = ctrl_addr_e'(fe_req.addr[ctrl_off_w+1:2]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_hit_cnt   <= '0;
            read_miss_cnt  <= '0;
            write_hit_cnt  <= '0;
            write_miss_cnt <= '0;
        end else if (counter_reset) begin
            read_hit_cnt   <= '0;
            read_miss_cnt  <= '0;
            write_hit_cnt  <= '0;
            write_miss_cnt <= '0;
        end else begin
            if (events.read_hit) read_hit_cnt <= read_hit_cnt + 1'b1;
            if (events.read_miss) read_miss_cnt <= read_miss_cnt + 1'b1;
            if (events.write_hit) write_hit_cnt <= write_hit_cnt + 1'b1;
            if (events.write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_q       <= 1'b0;
            invalidate    <= 1'b0;
            counter_reset <= 1'b0;
        end else begin
            ready_q       <= accept;  // answer next cycle
            invalidate    <= accept && (offset == ctrl_invalidate);
            counter_reset <= accept && (offset == ctrl_reset_counters);
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= '0;  // zero outside the ready cycle
        if (accept) begin
            case (offset)
                ctrl_hit:          rdata_q <= hit_cnt;
                ctrl_miss:         rdata_q <= miss_cnt;
                ctrl_read_hit:     rdata_q <= read_hit_cnt;
                ctrl_read_miss:    rdata_q <= read_miss_cnt;
                ctrl_write_hit:    rdata_q <= write_hit_cnt;
                ctrl_write_miss:   rdata_q <= write_miss_cnt;
                ctrl_buffer_empty: rdata_q <= {{(data_w-1){1'b0}}, wtbuf_empty};
                ctrl_buffer_full:  rdata_q <= {{(data_w-1){1'b0}}, wtbuf_full};
                default:           rdata_q <= '0;
            endcase
        end
    end

    assign fe_rsp.ready = ready_q;
    assign fe_rsp.rdata = rdata_q;

endmodule

/* src/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic [dcache_pkg::tag_w-1:0]   tag,
    output logic                          hit,
    output logic [dcache_pkg::data_w-1:0]  rdata,
    input  logic                          fill,
    input  logic [dcache_pkg::data_w-1:0]  fill_data,
    input  logic                          update,
    input  logic [dcache_pkg::data_w-1:0]  update_data,
    input  logic                          invalidate
);
    import dcache_pkg::*;

    logic [line_count-1:0] valid_bits;
    logic [tag_w-1:0]      tag_mem  [line_count];
    logic [data_w-1:0]     data_mem [line_count];

    // direct mapped, one compare
    assign hit   = valid_bits[index] && (tag_mem[index] == tag);
    assign rdata = data_mem[index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (invalidate) begin
            valid_bits <= '0;  // flash clear
        end else if (fill) begin
            valid_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= fill_data;
        end else if (update) begin
            data_mem[index] <= update_data;  // write hit keeps line current
        end
    end

endmodule

/* src/dcache_wtbuf.sv */
`timescale 1ns/1ps

module dcache_wtbuf (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  dcache_pkg::wt_entry_t push_entry,
    input  logic                  pop,
    output dcache_pkg::wt_entry_t head,
    output logic                  empty,
    output logic                  full
);
    import dcache_pkg::*;

    wt_entry_t              mem [wtbuf_depth];
    logic [wtbuf_ptr_w-1:0] wr_ptr;
    logic [wtbuf_ptr_w-1:0] rd_ptr;
    logic [wtbuf_ptr_w:0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (wtbuf_ptr_w + 1)'(wtbuf_depth));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

endmodule

/* src/dcache_core.sv */
`timescale 1ns/1ps

module dcache_core (
    input  logic                           clk,
    input  logic                           reset,
    input  dcache_pkg::fe_req_t            fe_req,
    output dcache_pkg::fe_rsp_t            fe_rsp,
    output dcache_pkg::be_req_t            be_req,
    input  dcache_pkg::be_rsp_t            be_rsp,
    output logic [dcache_pkg::index_w-1:0] index,
    output logic [dcache_pkg::tag_w-1:0]   tag,
    output logic                           fill,
    output logic [dcache_pkg::data_w-1:0]  fill_data,
    output logic                           update,
    output logic [dcache_pkg::data_w-1:0]  update_data,
    input  logic                           hit,
    input  logic [dcache_pkg::data_w-1:0]  rdata,
    output logic                           push,
    output dcache_pkg::wt_entry_t          push_entry,
    output logic                           pop,
    input  dcache_pkg::wt_entry_t          head,
    input  logic                           empty,
    input  logic                           full,
    output dcache_pkg::cache_event_t       events
);
    import dcache_pkg::*;

    core_state_e       state;
    core_state_e       state_next;
    logic [data_w-1:0] rdata_q;
    logic              lookup;
    logic              store_ok;
    logic              refill_req;
    logic              drain_req;

    assign lookup = (state == core_lookup);
    assign index  = fe_req.addr[index_w+1:2];
    assign tag    = fe_req.addr[addr_w-1:index_w+2];

    // store leaves in lookup, or later once the buffer has room
    assign store_ok         = fe_req.we && !full && (lookup || state == core_store);
    assign push             = store_ok;
    assign push_entry.addr  = fe_req.addr[addr_w-1:2];
    assign push_entry.wdata = fe_req.wdata;
    assign update           = store_ok && hit;
    assign update_data      = fe_req.wdata;

    assign events.read_hit   = lookup && !fe_req.we && hit;
    assign events.read_miss  = lookup && !fe_req.we && !hit;
    assign events.write_hit  = lookup && fe_req.we && hit;
    assign events.write_miss = lookup && fe_req.we && !hit;

    // refill only on an empty buffer, so reads see earlier stores
    assign refill_req   = (state == core_refill) && empty;
    assign drain_req    = !empty;
    assign be_req.valid = refill_req || drain_req;
    assign be_req.we    = drain_req;
    assign be_req.addr  = drain_req ? head.addr : fe_req.addr[addr_w-1:2];
    assign be_req.wdata = head.wdata;
    assign pop          = drain_req && be_rsp.ready;
    assign fill         = refill_req && be_rsp.ready;
    assign fill_data    = be_rsp.rdata;

    always_comb begin
        state_next = state;
        case (state)
            core_idle:   if (fe_req.valid) state_next = core_lookup;
            core_lookup: begin
                if (fe_req.we) begin
                    state_next = full ? core_store : core_done;
                end else begin
                    state_next = hit ? core_done : core_refill;
                end
            end
            core_refill: if (fill) state_next = core_done;
            core_store:  if (!full) state_next = core_done;
            default:     state_next = core_idle;  // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= core_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (events.read_hit) begin
            rdata_q <= rdata;
        end else if (fill) begin
            rdata_q <= be_rsp.rdata;
        end
    end

    assign fe_rsp.ready = (state == core_done);
    assign fe_rsp.rdata = (state == core_done && !fe_req.we) ? rdata_q : '0;

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::fe_req_t fe_req,
    output dcache_pkg::fe_rsp_t fe_rsp,
    output dcache_pkg::be_req_t be_req,
    input  dcache_pkg::be_rsp_t be_rsp
);
    import dcache_pkg::*;

    fe_req_t           core_req;
    fe_req_t           ctrl_req;
    fe_rsp_t           core_rsp;
    fe_rsp_t           ctrl_rsp;
    cache_event_t      events;
    logic [index_w-1:0] index;
    logic [tag_w-1:0]  tag;
    logic              hit;
    logic [data_w-1:0] store_rdata;
    logic              fill;
    logic [data_w-1:0] fill_data;
    logic              update;
    logic [data_w-1:0] update_data;
    logic              push;
    wt_entry_t         push_entry;
    logic              pop;
    wt_entry_t         head;
    logic              empty;
    logic              full;
    logic              invalidate;

    // top address bit selects the control space
    always_comb begin
        core_req       = fe_req;
        ctrl_req       = fe_req;
        core_req.valid = fe_req.valid && !fe_req.addr[addr_w-1];
        ctrl_req.valid = fe_req.valid && fe_req.addr[addr_w-1];
    end

    assign fe_rsp.ready = core_rsp.ready | ctrl_rsp.ready;
    assign fe_rsp.rdata = core_rsp.rdata | ctrl_rsp.rdata;  // idle side drives zero

    dcache_core core_i (
        .clk, .reset, .fe_req(core_req), .fe_rsp(core_rsp), .be_req, .be_rsp,
        .index, .tag, .fill, .fill_data, .update, .update_data,
        .hit, .rdata(store_rdata), .push, .push_entry, .pop,
        .head, .empty, .full, .events
    );

    dcache_store store_i (
        .clk, .reset, .index, .tag, .hit, .rdata(store_rdata),
        .fill, .fill_data, .update, .update_data, .invalidate
    );

    dcache_wtbuf wtbuf_i (
        .clk, .reset, .push, .push_entry, .pop, .head, .empty, .full
    );

    dcache_ctrl ctrl_i (
        .clk, .reset, .fe_req(ctrl_req), .fe_rsp(ctrl_rsp), .events,
        .wtbuf_empty(empty), .wtbuf_full(full), .invalidate
    );

endmodule

/* testbench/dcache_sva.sv */
`timescale 1ns/1ps

module dcache_sva (
    input logic                clk,
    input logic                reset,
    input dcache_pkg::fe_req_t fe_req,
    input dcache_pkg::fe_rsp_t fe_rsp,
    input dcache_pkg::be_req_t be_req,
    input dcache_pkg::be_rsp_t be_rsp
);
    import dcache_pkg::*;

    int   fail_count = 0;
    logic ctrl_valid;

    assign ctrl_valid = fe_req.valid && fe_req.addr[addr_w-1];  // control space

    fe_hold: assert property (@(posedge clk) disable iff (reset)
        fe_req.valid && !fe_rsp.ready |=> $stable(fe_req))
        else begin
            fail_count = fail_count + 1;
            $error("front-end request changed before ready");
        end

    be_hold: assert property (@(posedge clk) disable iff (reset)
        be_req.valid && !be_rsp.ready |=> $stable(be_req))
        else begin
            fail_count = fail_count + 1;
            $error("back-end request changed before ready");
        end

    ctrl_latency: assert property (@(posedge clk) disable iff (reset)
        ctrl_valid && !fe_rsp.ready |=> fe_rsp.ready)
        else begin
            fail_count = fail_count + 1;
            $error("control access not answered in the next cycle");
        end

endmodule

bind dcache_top dcache_sva sva_i (
    .clk(clk), .reset(reset), .fe_req(fe_req), .fe_rsp(fe_rsp),
    .be_req(be_req), .be_rsp(be_rsp)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb #(
    parameter int clk_period     = 20,
    parameter int reset_cycles   = 16,
    parameter int num_random     = 200,
    parameter int num_recount    = 30,
    parameter int test_words     = 64,
    parameter int burst_len      = 6,
    parameter int slow_latency   = 30,
    parameter int idle_cycles    = 100,
    parameter int cycles_per_req = 200
);
    import dcache_pkg::*;

    localparam int mem_words    = 1 << be_addr_w;
    localparam int max_requests = 2 * num_random + 2 * num_recount + 5 * 6 + 6 + burst_len;
    localparam int timeout_ns   =
        (reset_cycles + idle_cycles + max_requests * cycles_per_req) * clk_period;

    typedef struct packed {
        cache_event_t      kind;
        logic [data_w-1:0] rdata;
    } ref_result_t;

    logic    clk    = 1'b0;
    logic    reset  = 1'b1;
    fe_req_t fe_req = '0;
    fe_rsp_t fe_rsp;
    be_req_t be_req;
    be_rsp_t be_rsp = '0;

    integer seed     = 32'h0294_3df1;
    integer lat_seed = 32'h0294_3df1;  // memory latency stream
    int     mem_wait = 0;
    logic   slow_mem = 1'b0;

    logic [data_w-1:0]     mem_model  [mem_words];
    logic [data_w-1:0]     shadow_mem [mem_words];
    logic [tag_w-1:0]      shadow_tag [line_count];
    logic [line_count-1:0] shadow_valid   = '0;
    logic [data_w-1:0]     cnt_read_hit   = '0;
    logic [data_w-1:0]     cnt_read_miss  = '0;
    logic [data_w-1:0]     cnt_write_hit  = '0;
    logic [data_w-1:0]     cnt_write_miss = '0;

    dcache_top dcache_top_i (
        .clk(clk), .reset(reset), .fe_req(fe_req), .fe_rsp(fe_rsp),
        .be_req(be_req), .be_rsp(be_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    // back-end memory model serving one request at a time
    always @(posedge clk) begin
        logic [31:0] rnd;
        be_rsp.ready <= 1'b0;
        be_rsp.rdata <= '0;
        if (be_req.valid && !be_rsp.ready) begin
            if (mem_wait == 0) begin
                rnd      = $random(lat_seed);
                mem_wait = slow_mem ? slow_latency : 1 + int'(rnd % 32'd6);
            end else begin
                mem_wait = mem_wait - 1;
                if (mem_wait == 0) begin
                    be_rsp.ready <= 1'b1;
                    if (be_req.we) begin
                        mem_model[be_req.addr] = be_req.wdata;  // arrival order
                    end else begin
                        be_rsp.rdata <= mem_model[be_req.addr];
                    end
                end
            end
        end
    end

    function automatic logic [data_w-1:0] fill_word(input logic [be_addr_w-1:0] word);
        return {2'b10, word ^ 14'h1e35, 2'b01, word};
    endfunction

    // predicts one access and updates shadow state and counts
    function automatic ref_result_t predict(input logic we, input logic [addr_w-1:0] addr,
                                            input logic [data_w-1:0] wdata);
        ref_result_t          res;
        logic [index_w-1:0]   idx;
        logic [tag_w-1:0]     line_tag;
        logic [be_addr_w-1:0] word;
        logic                 is_hit;
        idx      = addr[index_w+1:2];
        line_tag = addr[addr_w-1:index_w+2];
        word     = addr[addr_w-1:2];
        is_hit   = shadow_valid[idx] && (shadow_tag[idx] == line_tag);
        res      = '0;
        if (we) begin
            shadow_mem[word]    = wdata;  // no allocate on miss
            res.kind.write_hit  = is_hit;
            res.kind.write_miss = !is_hit;
        end else begin
            res.rdata          = shadow_mem[word];
            res.kind.read_hit  = is_hit;
            res.kind.read_miss = !is_hit;
            shadow_valid[idx]  = 1'b1;
            shadow_tag[idx]    = line_tag;
        end
        cnt_read_hit   = cnt_read_hit + data_w'(res.kind.read_hit);
        cnt_read_miss  = cnt_read_miss + data_w'(res.kind.read_miss);
        cnt_write_hit  = cnt_write_hit + data_w'(res.kind.write_hit);
        cnt_write_miss = cnt_write_miss + data_w'(res.kind.write_miss);
        return res;
    endfunction

    function automatic logic [data_w-1:0] expected_ctrl(input ctrl_addr_e off);
        case (off)
            ctrl_hit:        return cnt_read_hit + cnt_write_hit;
            ctrl_miss:       return cnt_read_miss + cnt_write_miss;
            ctrl_read_hit:   return cnt_read_hit;
            ctrl_read_miss:  return cnt_read_miss;
            ctrl_write_hit:  return cnt_write_hit;
            ctrl_write_miss: return cnt_write_miss;
            default:         return '0;
        endcase
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input fe_rsp_t got, input fe_rsp_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: control read %s gave ready %0b data 0x%08h, expected 0x%08h",
                     $time, what, got.ready, got.rdata, exp.rdata);
            abort_run();
        end
    endtask

    task automatic issue_request(input logic we, input logic [addr_w-1:0] addr,
                                 input logic [data_w-1:0] wdata,
                                 output fe_rsp_t rsp, output int waits);
        @(posedge clk);
        fe_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
        waits = 0;
        @(negedge clk);
        while (!fe_rsp.ready) begin
            waits++;
            @(negedge clk);
        end
        rsp = fe_rsp;
        @(posedge clk);
        fe_req.valid <= 1'b0;
    endtask

    task automatic mem_access(input logic we, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] wdata);
        ref_result_t exp;
        fe_rsp_t     rsp;
        int          waits;
        exp = predict(we, addr, wdata);
        issue_request(we, addr, wdata, rsp, waits);
        if (!we) begin
            check_data(rsp.rdata, exp.rdata, $sformatf("read of 0x%04h", addr));
        end
        if (exp.kind.read_hit && waits != 2) begin
            $display("error at %0t ns: read hit of 0x%04h answered after %0d cycles, expected 2",
                     $time, addr, waits);
            abort_run();
        end
    endtask

    task automatic ctrl_access(input ctrl_addr_e off, input logic [data_w-1:0] exp_data);
        fe_rsp_t           rsp;
        fe_rsp_t           exp_rsp;
        int                waits;
        logic [addr_w-1:0] addr;
        addr                 = '0;
        addr[addr_w-1]       = 1'b1;  // control space
        addr[ctrl_off_w+1:2] = off;
        issue_request(1'b0, addr, '0, rsp, waits);
        if (waits != 1) begin
            $display("error at %0t ns: control read %s answered after %0d cycles, expected 1",
                     $time, off.name(), waits);
            abort_run();
        end
        exp_rsp.ready = 1'b1;
        exp_rsp.rdata = exp_data;
        check_ctrl(rsp, exp_rsp, off.name());
        if (off == ctrl_reset_counters) begin
            cnt_read_hit   = '0;
            cnt_read_miss  = '0;
            cnt_write_hit  = '0;
            cnt_write_miss = '0;
        end
        if (off == ctrl_invalidate) shadow_valid = '0;
    endtask

    task automatic check_counters();
        ctrl_addr_e off;
        off = ctrl_hit;
        repeat (6) begin  // hit through write_miss
            ctrl_access(off, expected_ctrl(off));
            off = off.next();
        end
    endtask

    task automatic run_random(input int n);
        logic [addr_w-1:0] addr;
        logic [31:0]       rnd;
        logic [31:0]       wdata;
        for (int i = 0; i < n; i++) begin
            rnd       = $random(seed);
            addr      = '0;
            addr[7:2] = rnd[5:0];  // 64 words over four tags per line
            wdata     = $random(seed);
            case (rnd[9:8])
                2'd1:    mem_access(1'b1, addr, wdata);
                2'd2: begin
                    mem_access(1'b1, addr, wdata);
                    mem_access(1'b0, addr, '0);  // store may still sit in the buffer
                end
                default: mem_access(1'b0, addr, '0);
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (dcache_top_i.sva_i.fail_count != 0) begin
            $display("a handshake assertion failed near %0t ns", $time);
            abort_run();
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the cache stopped answering requests within %0d ns", timeout_ns);
        abort_run();
    end

    initial begin
        logic [addr_w-1:0] baddr;
        for (int i = 0; i < mem_words; i++) begin
            mem_model[i]  = fill_word(i[be_addr_w-1:0]);
            shadow_mem[i] = mem_model[i];
        end
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        run_random(num_random);
        check_counters();

        ctrl_access(ctrl_reset_counters, '0);
        check_counters();
        run_random(num_recount);
        check_counters();

        mem_access(1'b0, 16'h0024, '0);
        ctrl_access(ctrl_invalidate, '0);
        mem_access(1'b0, 16'h0024, '0);  // now a read miss
        check_counters();

        slow_mem <= 1'b1;
        baddr    = 16'h0040;
        for (int i = 0; i < burst_len; i++) begin
            mem_access(1'b1, baddr, {16'hc0de, baddr});
            baddr = baddr + 16'd4;
        end
        ctrl_access(ctrl_buffer_full, 32'd1);
        slow_mem <= 1'b0;
        repeat (idle_cycles) @(posedge clk);
        ctrl_access(ctrl_buffer_empty, 32'd1);
        for (int w = 0; w < test_words; w++) begin
            check_data(mem_model[w], shadow_mem[w], $sformatf("memory word %0d", w));
        end
        check_counters();

        if (dcache_top_i.sva_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("handshake assertions failed %0d times", dcache_top_i.sva_i.fail_count);
            abort_run();
        end
    end

endmodule

/* src.f */
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/dcache_store.sv
src/dcache_wtbuf.sv
src/dcache_core.sv
src/dcache_top.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f src.f \
    -Mdir obj_dir -o sim_dcache \
    && out="$(./obj_dir/sim_dcache +verilator+error+limit+100 2>&1)"
printf '%s\n' "$out"
grep -q "Simulation finished: PASS" <<< "$out" \
    && echo "dcache run passed" \
    || { echo "dcache run did not pass"; exit 1; }
